/* all.f */
common/us_pkg.sv
verilog/us_sample_fifo.sv
verilog/us_discovery_reply.sv
packer/us_frame_packer.sv
verilog/us_tx_arbiter.sv
verilog/us_upstream_top.sv
bench/tb_clock.sv
bench/tb_upstream.sv

/* bench/tb_clock.sv */
// Free-running 100 ns clock; rst_n released after four rising edges
`timescale 1ns/1ps

module tb_clock #(
  parameter int period_ns = 100
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  initial begin
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* bench/tb_upstream.sv */
// Acts as sample source and UDP transmitter; only one packet is in flight and only it grants requests
`timescale 1ns/1ps

module tb_upstream import us_pkg::*;;

  localparam logic [7:0] BOARD_NR   = 8'h5a;
  localparam logic [7:0] SERIAL_NO  = 8'h21;
  localparam int         NUM_PKTS   = 18;  // Data and discovery packets together
  localparam longint     WATCHDOG_NS = (NUM_PKTS * DATA_LEN + 30000) * 100;

  logic clk, rst_n, have_ip, run, board_hl, discovery, udp_tx_enable, udp_tx_request;
  logic [7:0] udp_tx_data;
  pkt_len_t udp_tx_length;
  sample_t sample_data;
  logic sample_last, sample_mic, sample_valid, sample_ready, cmd_rqst, resp_rqst;
  logic [5:0] cmd_addr;
  logic [31:0] cmd_data;
  resp_t resp;
  mac_t mac;

  logic [31:0] lfsr = 32'd50;
  logic [25:0] word_q[$];      // {last, mic, data} as accepted by the FIFO
  resp_t resp_hist[$];         // resp value in force for each subframe
  logic [7:0] pkt [0:DATA_LEN-1];
  int p, sf_idx, toggles, pkt_done, disc_done, disc_pending, fed, feed_limit, round_len;
  int err_byte, err_len, err_seq, err_other;
  logic vna_exp, block_data, hold_tx, in_pkt, cur_data;
  seq_t seq_exp;

  tb_clock u_clk (.clk(clk), .rst_n(rst_n));

  us_upstream_top #(.board_nr(BOARD_NR), .serial_no(SERIAL_NO)) dut0 (.*);

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r    = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic check_byte(int idx, logic [7:0] got, logic [7:0] exp);
    if (got !== exp) begin
      err_byte++;
      $display("Error udp_tx_data[%0d]: got %h expected %h", idx, got, exp);
    end
  endtask

  task automatic check_length(pkt_len_t got, pkt_len_t exp);
    if (got !== exp) begin
      err_len++;
      $display("Error udp_tx_length: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_seq(seq_t got, seq_t exp);
    if (got !== exp) begin
      err_seq++;
      $display("Error udp_tx_data sequence number: got %h expected %h", got, exp);
    end
  endtask

  task automatic expect_byte(logic [7:0] exp);
    check_byte(p, pkt[p], exp);
    p++;
  endtask

  function automatic logic [7:0] disc_expected(int i);
    logic [63:0] id;
    id = "HERMESLT";
    if (i == 0) return 8'hef;
    if (i == 1) return 8'hfe;
    if (i == 2) return run ? 8'h03 : 8'h02;
    if (i <= 8) return mac[47 - 8 * (i - 3) -: 8];
    if (i == 9) return SERIAL_NO;
    if (i <= 17) return id[63 - 8 * (i - 10) -: 8];
    if (i == 18) return BOARD_NR;
    return board_hl ? 8'h06 : 8'h01;
  endfunction

  task automatic check_data();
    logic [25:0] w;
    int cnt;
    int rl;
    int rem;
    p = 0;
    expect_byte(8'hef);
    expect_byte(8'hfe);
    expect_byte(8'h01);
    expect_byte(8'h06);
    check_seq({pkt[4], pkt[5], pkt[6], pkt[7]}, seq_exp);
    seq_exp++;
    p = 8;
    for (int sf = 0; sf < 2; sf++) begin
      repeat (3) expect_byte(8'h7f);
      for (int b = 4; b >= 0; b--) expect_byte(resp_hist[sf_idx][8 * b +: 8]);
      sf_idx++;
      rem = SUBFRAME_LEN - 8;
      do begin
        cnt = 0;
        do begin
          if (word_q.size() == 0) begin
            err_other++;
            $display("Model ran out of samples inside a subframe");
            return;
          end
          w = word_q.pop_front();
          expect_byte(w[23:16]);
          expect_byte(w[15:8]);
          expect_byte(w[7:0]);
          cnt++;
        end while (!w[25]);
        expect_byte(8'h00);
        expect_byte(vna_exp ? {7'b0, w[24]} : 8'h00);
        rl  = 3 * cnt + 2;
        rem = rem - rl;
      end while (rem >= rl);   // Next round only if the last one fits again
      repeat (rem) expect_byte(8'h00);
    end
    if (toggles != sf_idx) begin
      err_other++;
      $display("resp_rqst toggled %0d times for %0d subframes", toggles, sf_idx);
    end
  endtask

  // UDP transmitter side
  initial begin
    int n;
    int wait_cnt;
    logic is_disc;
    forever begin
      @(negedge clk);
      if (udp_tx_request === 1'b1) begin
        is_disc = (disc_pending > 0);
        n       = is_disc ? DISC_LEN : DATA_LEN;
        check_length(udp_tx_length, pkt_len_t'(n));
        if (!is_disc && block_data) begin
          err_other++;
          $display("Data request while have_ip, run or the FIFO level forbids it");
        end
        wait_cnt = 0;
        while (!is_disc && hold_tx && sample_ready && wait_cnt < 3000) begin
          @(negedge clk);
          wait_cnt++;
        end
        if (wait_cnt >= 3000) begin
          err_other++;
          $display("sample_ready never fell while packets were held back");
        end
        repeat (rand_bits(2)) @(posedge clk);
        @(posedge clk) udp_tx_enable <= 1'b1;
        @(posedge clk) udp_tx_enable <= 1'b0;
        cur_data = !is_disc;
        in_pkt   = 1'b1;
        for (int i = 0; i < n; i++) begin
          @(negedge clk);
          pkt[i] = udp_tx_data;
        end
        in_pkt = 1'b0;
        if (is_disc) begin
          for (int i = 0; i < n; i++) check_byte(i, pkt[i], disc_expected(i));
          disc_pending--;
          disc_done++;
        end else begin
          check_data();
          pkt_done++;
        end
      end
    end
  end

  // Sample source feeding rounds of round_len words
  initial begin
    int pos;
    logic acc;
    logic run_n;
    logic mic_r;
    pos = 0;
    forever begin
      @(negedge clk);
      acc   = sample_valid && sample_ready && run;
      run_n = run;
      @(posedge clk);
      if (acc) begin
        word_q.push_back({sample_last, sample_mic, sample_data});
        fed++;
        pos = sample_last ? 0 : pos + 1;
      end
      if (!run_n) pos = 0;  // Flushed FIFO starts on a round boundary
      if (acc || !run_n) begin
        if (pos == 0) mic_r = 1'(rand_bits(1));
        sample_data <= sample_t'(rand_bits(24));
        sample_mic  <= mic_r;
        sample_last <= (pos == round_len - 1);
      end
      sample_valid <= run_n && (fed < feed_limit);
    end
  end

  // New resp after each toggle
  initial begin
    logic last_rqst;
    resp_t nxt;
    last_rqst = 1'b0;
    forever begin
      @(negedge clk);
      if (resp_rqst !== last_rqst) begin
        last_rqst = resp_rqst;
        toggles++;
        nxt = resp_t'(rand_bits(40));
        resp_hist.push_back(nxt);
        @(posedge clk) resp <= nxt;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: packets stopped arriving before the test sequence ended");
    $display("SOME TESTS FAILED");
    $finish;
  end

  task automatic set_vna(logic v);
    @(posedge clk);
    cmd_rqst <= 1'b1;
    cmd_addr <= CMD_ADDR_VNA;
    cmd_data <= {8'h00, v, 23'(rand_bits(23))};
    @(posedge clk);
    cmd_addr <= 6'h0a;  // Opposite flag on another address must not stick
    cmd_data <= {8'h00, ~v, 23'h0};
    @(posedge clk) cmd_rqst <= 1'b0;
  endtask

  task automatic send_discovery();
    int target;
    target = disc_done + 1;
    disc_pending++;
    @(posedge clk) discovery <= 1'b1;
    @(posedge clk) discovery <= 1'b0;
    while (disc_done < target) @(posedge clk);
  endtask

  task automatic wait_packets(int n);
    int target;
    target = pkt_done + n;
    while (pkt_done < target) @(posedge clk);
  endtask

  task automatic start_run(int rl, logic v, int limit, logic window);
    @(posedge clk) have_ip <= 1'b0;
    repeat (3) @(posedge clk);
    while (udp_tx_request || in_pkt) @(posedge clk);
    run <= 1'b0;
    repeat (4) @(posedge clk);
    word_q.delete();
    seq_exp    = 0;
    round_len  = rl;
    vna_exp    = v;
    set_vna(v);
    fed        = 0;
    feed_limit = limit;
    block_data = window;
    @(posedge clk);
    run     <= 1'b1;
    have_ip <= 1'b1;
  endtask

  initial begin
    {have_ip, run, board_hl, discovery, udp_tx_enable, cmd_rqst} = '0;
    {sample_data, sample_last, sample_mic, sample_valid} = '0;
    cmd_addr   = '0;
    cmd_data   = '0;
    resp       = '0;
    resp_hist.push_back('0);
    mac        = mac_t'(rand_bits(48));
    round_len  = 1;
    feed_limit = 1 << 30;
    vna_exp    = 1'b0;
    block_data = 1'b1;
    {hold_tx, in_pkt, cur_data} = '0;
    wait (rst_n === 1'b1);
    repeat (2) @(posedge clk);
    send_discovery();                  // run and board_hl low
    @(posedge clk) board_hl <= 1'b1;
    send_discovery();
    set_vna(1'b0);
    @(posedge clk) run <= 1'b1;        // have_ip still low so the FIFO fills
    repeat (1200) @(posedge clk);
    if (sample_ready) begin
      err_other++;
      $display("sample_ready stayed high with the FIFO full");
    end
    if (fed != FIFO_DEPTH) begin
      err_other++;
      $display("FIFO took %0d words before sample_ready fell instead of its depth %0d",
               fed, FIFO_DEPTH);
    end
    send_discovery();                  // run and board_hl high
    @(posedge clk) board_hl <= 1'b0;
    block_data = 1'b0;
    @(posedge clk) have_ip <= 1'b1;
    wait_packets(3);
    start_run(2, 1'b1, 333, 1'b1);     // One word short of the threshold
    repeat (600) @(posedge clk);
    block_data = 1'b0;
    feed_limit = 1 << 30;
    wait_packets(1);
    wait (in_pkt && cur_data);
    repeat (50) @(posedge clk);
    send_discovery();                  // Served after the current packet
    wait_packets(1);
    hold_tx = 1'b1;
    start_run(3, 1'b0, 1 << 30, 1'b0);
    wait_packets(2);
    hold_tx = 1'b0;
    wait_packets(1);
    start_run(4, 1'b1, 1 << 30, 1'b0);
    wait_packets(3);
    $display("Errors: byte %0d, length %0d, sequence %0d, other %0d",
             err_byte, err_len, err_seq, err_other);
    if (err_byte + err_len + err_seq + err_other == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* common/us_pkg.sv */
// Sizes fixed for 1032-byte data packets and 60-byte discovery replies; FIFO depth must stay 2**FIFO_AW
package us_pkg;

  // Payload and field types
  typedef logic [23:0] sample_t;      // One receiver word, I/Q packed
  typedef logic [10:0] pkt_len_t;     // UDP payload length
  typedef logic [31:0] seq_t;         // Data packet sequence number
  typedef logic [39:0] resp_t;        // Response word after each sync
  typedef logic [47:0] mac_t;         // Station address
  typedef logic [10:0] fifo_level_t;  // Sample FIFO fill count

  // Packet geometry
  localparam pkt_len_t DISC_LEN     = 11'd60;
  localparam pkt_len_t DATA_LEN     = 11'd1032;
  localparam pkt_len_t SUBFRAME_LEN = 11'd512;

  // Header words
  localparam logic [7:0] SYNC_BYTE  = 8'h7f;
  localparam logic [7:0] PKT_ID0    = 8'hef;
  localparam logic [7:0] PKT_ID1    = 8'hfe;
  localparam logic [7:0] DATA_TAG   = 8'h01;
  localparam logic [7:0] DATA_EP    = 8'h06;

  // Enough words buffered to fill both subframes without stalling
  localparam fifo_level_t SEND_THRESHOLD = 11'd334;

  // Sample buffer
  localparam int          FIFO_AW    = 10;
  localparam fifo_level_t FIFO_DEPTH = 11'd1024;

  // Command port
  localparam logic [5:0] CMD_ADDR_VNA = 6'h09;
  localparam int         VNA_BIT      = 23;

  // Discovery reply codes
  localparam logic [7:0] DISC_RUNNING = 8'h03;
  localparam logic [7:0] DISC_IDLE    = 8'h02;
  localparam logic [7:0] BOARD_HL     = 8'h06;
  localparam logic [7:0] BOARD_OTHER  = 8'h01;

endpackage

/* packer/us_frame_packer.sv */
// Assumes enough FIFO words are buffered at start; never waits on the FIFO during a packet
`timescale 1ns/1ps

module us_frame_packer import us_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        run,
  input  logic        pkt_start,
  input  sample_t     head_data,
  input  logic        head_last,
  input  logic        head_mic,
  input  resp_t       resp,
  input  logic [5:0]  cmd_addr,
  input  logic [31:0] cmd_data,
  input  logic        cmd_rqst,
  output logic        pop,
  output logic [7:0]  pkt_byte,
  output logic        resp_rqst
);

  // State names the kind of byte loaded at the next edge
  typedef enum logic [2:0] {
    S_IDLE,
    S_HDR,
    S_SYNC,
    S_SAMP,
    S_MIC1,
    S_MIC0,
    S_PAD
  } state_t;

  state_t     state;
  logic [2:0] hdr_cnt;     // Header byte index to load
  logic [2:0] sync_cnt;    // Sync/response byte index to load
  logic [1:0] phase;       // Byte of the current sample word
  logic       second;      // Working on the second subframe
  pkt_len_t   sub_left;    // Subframe loads left, this one included
  pkt_len_t   round_cnt;   // Bytes of the current round so far
  seq_t       seq;
  logic       vna;
  logic       mic_bit;
  logic       body;
  logic       sub_end;
  pkt_len_t   room;
  pkt_len_t   round_total;

  assign body        = (state != S_IDLE) && (state != S_HDR);
  assign sub_end     = body && (sub_left == 11'd1);
  assign room        = sub_left - 11'd1;     // Bytes left after this load
  assign round_total = round_cnt + 11'd1;    // Round length once the last mic byte is in
  assign pop         = (state == S_SAMP) && (phase == 2'd2);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vna <= 1'b0;
    end else if (cmd_rqst && (cmd_addr == CMD_ADDR_VNA)) begin
      vna <= cmd_data[VNA_BIT];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      hdr_cnt   <= '0;
      sync_cnt  <= '0;
      phase     <= '0;
      second    <= 1'b0;
      sub_left  <= '0;
      round_cnt <= '0;
      seq       <= '0;
      mic_bit   <= 1'b0;
      resp_rqst <= 1'b0;
      pkt_byte  <= PKT_ID0;
    end else begin
      if (body) sub_left <= sub_left - 11'd1;

      case (state)
        S_IDLE: begin
          pkt_byte <= PKT_ID0;  // Byte 0 waits on the output
          if (pkt_start) begin
            pkt_byte <= PKT_ID1;
            hdr_cnt  <= 3'd2;
            second   <= 1'b0;
            state    <= S_HDR;
          end
        end
        S_HDR: begin
          hdr_cnt <= hdr_cnt + 3'd1;
          case (hdr_cnt)
            3'd2:    pkt_byte <= DATA_TAG;
            3'd3:    pkt_byte <= DATA_EP;
            3'd4:    pkt_byte <= seq[31:24];
            3'd5:    pkt_byte <= seq[23:16];
            3'd6:    pkt_byte <= seq[15:8];
            default: pkt_byte <= seq[7:0];
          endcase
          if (hdr_cnt == 3'd7) begin
            seq      <= seq + 32'd1;
            sync_cnt <= '0;
            sub_left <= SUBFRAME_LEN;
            state    <= S_SYNC;
          end
        end
        S_SYNC: begin
          sync_cnt <= sync_cnt + 3'd1;
          case (sync_cnt)
            3'd0, 3'd1, 3'd2: pkt_byte <= SYNC_BYTE;
            3'd3:    pkt_byte <= resp[39:32];
            3'd4:    pkt_byte <= resp[31:24];
            3'd5:    pkt_byte <= resp[23:16];
            3'd6:    pkt_byte <= resp[15:8];
            default: pkt_byte <= resp[7:0];
          endcase
          if (sync_cnt == 3'd7) begin
            resp_rqst <= ~resp_rqst;  // resp may change from next cycle
            phase     <= '0;
            round_cnt <= '0;
            state     <= S_SAMP;  // First round always starts
          end
        end
        S_SAMP: begin
          round_cnt <= round_cnt + 11'd1;
          case (phase)
            2'd0: begin
              pkt_byte <= head_data[23:16];
              phase    <= 2'd1;
            end
            2'd1: begin
              pkt_byte <= head_data[15:8];
              phase    <= 2'd2;
            end
            default: begin
              pkt_byte <= head_data[7:0];  // Word popped on this edge
              phase    <= 2'd0;
              mic_bit  <= head_mic;
              if (head_last) state <= S_MIC1;
            end
          endcase
        end
        S_MIC1: begin
          round_cnt <= round_cnt + 11'd1;
          pkt_byte  <= 8'h00;
          state     <= S_MIC0;
        end
        S_MIC0: begin
          round_cnt <= '0;
          pkt_byte  <= vna ? {7'b0, mic_bit} : 8'h00;
          state     <= (room >= round_total) ? S_SAMP : S_PAD;  // Room for another round
        end
        S_PAD: begin
          pkt_byte <= 8'h00;
        end
        default: state <= S_IDLE;
      endcase

      // Last load of a subframe overrides the next state
      if (sub_end) begin
        phase     <= '0;
        round_cnt <= '0;
        if (!second) begin
          second   <= 1'b1;
          sync_cnt <= '0;
          sub_left <= SUBFRAME_LEN;
          state    <= S_SYNC;
        end else begin
          state <= S_IDLE;
        end
      end

      if (!run) seq <= '0;  // Numbering restarts with each run
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_upstream -f all.f -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED" && exit 0 || exit 1

/* verilog/us_discovery_reply.sv */
// Idle output already holds the first reply byte so the arbiter sees byte 0 on the grant cycle
`timescale 1ns/1ps

module us_discovery_reply import us_pkg::*; #(
  parameter logic [7:0] board_nr  = 8'h00,
  parameter logic [7:0] serial_no = 8'h00
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       disc_start,
  input  logic       run,
  input  logic       board_hl,
  input  mac_t       mac,
  output logic [7:0] disc_byte
);

  logic     busy;
  pkt_len_t idx;        // Index of the byte now on disc_byte
  pkt_len_t idx_next;
  logic     busy_next;
  logic [7:0] byte_next;

  always_comb begin
    idx_next  = idx;
    busy_next = busy;
    if (!busy) begin
      idx_next = '0;
      if (disc_start) begin
        idx_next  = 11'd1;
        busy_next = 1'b1;
      end
    end else if (idx == DISC_LEN - 11'd1) begin
      idx_next  = '0;  // Back to the preloaded first byte
      busy_next = 1'b0;
    end else begin
      idx_next = idx + 11'd1;
    end
  end

  always_comb begin
    case (idx_next)
      11'd0:   byte_next = PKT_ID0;
      11'd1:   byte_next = PKT_ID1;
      11'd2:   byte_next = run ? DISC_RUNNING : DISC_IDLE;
      11'd3:   byte_next = mac[47:40];  // MAC, MSB first
      11'd4:   byte_next = mac[39:32];
      11'd5:   byte_next = mac[31:24];
      11'd6:   byte_next = mac[23:16];
      11'd7:   byte_next = mac[15:8];
      11'd8:   byte_next = mac[7:0];
      11'd9:   byte_next = serial_no;
      11'd10:  byte_next = "H";
      11'd11:  byte_next = "E";
      11'd12:  byte_next = "R";
      11'd13:  byte_next = "M";
      11'd14:  byte_next = "E";
      11'd15:  byte_next = "S";
      11'd16:  byte_next = "L";
      11'd17:  byte_next = "T";
      11'd18:  byte_next = board_nr;
      default: byte_next = board_hl ? BOARD_HL : BOARD_OTHER;  // Tail fill
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      idx       <= '0;
      disc_byte <= PKT_ID0;
    end else begin
      busy      <= busy_next;
      idx       <= idx_next;
      disc_byte <= byte_next;
    end
  end

endmodule

/* verilog/us_sample_fifo.sv */
// Head word is read asynchronously from the array; contents are discarded whenever run is low
`timescale 1ns/1ps

module us_sample_fifo import us_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        run,
  input  sample_t     sample_data,
  input  logic        sample_last,
  input  logic        sample_mic,
  input  logic        sample_valid,
  input  logic        pop,
  output logic        sample_ready,
  output sample_t     head_data,
  output logic        head_last,
  output logic        head_mic,
  output fifo_level_t level
);

  logic [25:0]        mem [0:FIFO_DEPTH-1];  // {last, mic, data}
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic               push;
  logic               pull;
  fifo_level_t        level_next;

  assign push = sample_valid && sample_ready && run;
  assign pull = pop && (level != '0);  // Ignore pop on empty

  always_comb begin
    level_next = level;
    if (push && !pull) level_next = level + 11'd1;
    else if (pull && !push) level_next = level - 11'd1;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      level        <= '0;
      sample_ready <= 1'b0;
    end else if (!run) begin
      // Flush so the next run starts on a round boundary
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      level        <= '0;
      sample_ready <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pull) rd_ptr <= rd_ptr + 1'b1;
      level        <= level_next;
      sample_ready <= (level_next != FIFO_DEPTH);  // Drops the cycle after it fills
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= {sample_last, sample_mic, sample_data};
  end

  assign head_data = mem[rd_ptr][23:0];
  assign head_mic  = mem[rd_ptr][24];
  assign head_last = mem[rd_ptr][25];

endmodule

/* verilog/us_tx_arbiter.sv */
// Sources must present byte 0 before their start strobe; bytes are steered for exactly the length
`timescale 1ns/1ps

module us_tx_arbiter import us_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        discovery,
  input  logic        have_ip,
  input  logic        run,
  input  fifo_level_t level,
  input  logic        udp_tx_enable,
  input  logic [7:0]  disc_byte,
  input  logic [7:0]  pkt_byte,
  output logic        udp_tx_request,
  output pkt_len_t    udp_tx_length,
  output logic [7:0]  udp_tx_data,
  output logic        disc_start,
  output logic        pkt_start
);

  typedef enum logic [1:0] {A_IDLE, A_REQ, A_SEND} arb_state_t;

  arb_state_t state;
  logic       disc_pend;  // Discovery waiting to be served
  logic       sel_disc;   // Current source is the discovery reply
  pkt_len_t   cnt;        // Bytes left after the current one

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state          <= A_IDLE;
      disc_pend      <= 1'b0;
      sel_disc       <= 1'b0;
      cnt            <= '0;
      udp_tx_request <= 1'b0;
      udp_tx_length  <= '0;
      disc_start     <= 1'b0;
      pkt_start      <= 1'b0;
    end else begin
      disc_start <= 1'b0;
      pkt_start  <= 1'b0;
      case (state)
        A_IDLE: begin
          if (discovery || disc_pend) begin
            sel_disc       <= 1'b1;
            udp_tx_length  <= DISC_LEN;
            udp_tx_request <= 1'b1;
            state          <= A_REQ;
          end else if (have_ip && run && (level >= SEND_THRESHOLD)) begin
            sel_disc       <= 1'b0;
            udp_tx_length  <= DATA_LEN;
            udp_tx_request <= 1'b1;
            state          <= A_REQ;
          end
        end
        A_REQ: begin
          if (udp_tx_enable) begin
            udp_tx_request <= 1'b0;
            disc_start     <= sel_disc;
            pkt_start      <= !sel_disc;
            cnt            <= udp_tx_length - 11'd1;
            state          <= A_SEND;
          end
        end
        default: begin
          cnt <= cnt - 11'd1;
          if (cnt == '0) state <= A_IDLE;
        end
      endcase

      // Pending flag cleared at grant; a fresh pulse on that edge is kept
      if ((state == A_REQ) && udp_tx_enable && sel_disc) disc_pend <= 1'b0;
      if (discovery) disc_pend <= 1'b1;
    end
  end

  always_comb begin
    udp_tx_data = 8'h00;
    if (state == A_SEND) udp_tx_data = sel_disc ? disc_byte : pkt_byte;
  end

endmodule

/* verilog/us_upstream_top.sv */
// Board identity parameters only appear in the discovery reply; any values are accepted
`timescale 1ns/1ps

module us_upstream_top import us_pkg::*; #(
  parameter logic [7:0] board_nr  = 8'h00,
  parameter logic [7:0] serial_no = 8'h00
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        have_ip,
  input  logic        run,
  input  logic        board_hl,
  input  mac_t        mac,
  input  logic        discovery,
  input  logic        udp_tx_enable,
  output logic        udp_tx_request,
  output logic [7:0]  udp_tx_data,
  output pkt_len_t    udp_tx_length,
  input  sample_t     sample_data,
  input  logic        sample_last,
  input  logic        sample_mic,
  input  logic        sample_valid,
  output logic        sample_ready,
  input  logic [5:0]  cmd_addr,
  input  logic [31:0] cmd_data,
  input  logic        cmd_rqst,
  input  resp_t       resp,
  output logic        resp_rqst
);

  sample_t     head_data;
  logic        head_last;
  logic        head_mic;
  fifo_level_t level;
  logic        pop;
  logic        disc_start;
  logic        pkt_start;
  logic [7:0]  disc_byte;
  logic [7:0]  pkt_byte;

  us_sample_fifo u_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .run          (run),
    .sample_data  (sample_data),
    .sample_last  (sample_last),
    .sample_mic   (sample_mic),
    .sample_valid (sample_valid),
    .pop          (pop),
    .sample_ready (sample_ready),
    .head_data    (head_data),
    .head_last    (head_last),
    .head_mic     (head_mic),
    .level        (level)
  );

  us_frame_packer u_packer (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .pkt_start (pkt_start),
    .head_data (head_data),
    .head_last (head_last),
    .head_mic  (head_mic),
    .resp      (resp),
    .cmd_addr  (cmd_addr),
    .cmd_data  (cmd_data),
    .cmd_rqst  (cmd_rqst),
    .pop       (pop),
    .pkt_byte  (pkt_byte),
    .resp_rqst (resp_rqst)
  );

  us_discovery_reply #(
    .board_nr  (board_nr),
    .serial_no (serial_no)
  ) u_disc (
    .clk        (clk),
    .rst_n      (rst_n),
    .disc_start (disc_start),
    .run        (run),
    .board_hl   (board_hl),
    .mac        (mac),
    .disc_byte  (disc_byte)
  );

  us_tx_arbiter u_arb (
    .clk            (clk),
    .rst_n          (rst_n),
    .discovery      (discovery),
    .have_ip        (have_ip),
    .run            (run),
    .level          (level),
    .udp_tx_enable  (udp_tx_enable),
    .disc_byte      (disc_byte),
    .pkt_byte       (pkt_byte),
    .udp_tx_request (udp_tx_request),
    .udp_tx_length  (udp_tx_length),
    .udp_tx_data    (udp_tx_data),
    .disc_start     (disc_start),
    .pkt_start      (pkt_start)
  );

endmodule
